/* source/dm_pkg.sv */
`default_nettype none

package dm_pkg;

  // --------------------
  // basic widths
  // --------------------
  typedef logic [6:0]  dm_addr_t;
  typedef logic [31:0] dm_word_t;
  typedef logic [19:0] hartsel_t;

  typedef enum logic [1:0] {
    DtmNop   = 2'h0,
    DtmRead  = 2'h1,
    DtmWrite = 2'h2
  } dtm_op_e;

  typedef struct packed {
    dm_addr_t addr;
    dtm_op_e  op;
    dm_word_t data;
  } dmi_req_t;

  typedef struct packed {
    dm_word_t   data;
    logic [1:0] resp;
  } dmi_resp_t;

  localparam logic [1:0] DtmSuccess = 2'h0;

  typedef enum logic [2:0] {
    CmdErrNone         = 3'd0,
    CmdErrBusy         = 3'd1,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3,
    CmdErrHaltResume   = 3'd4,
    CmdErrBus          = 3'd5,
    CmdErrOther        = 3'd7
  } cmderr_e;

  // --------------------
  // register layouts
  // --------------------
  typedef struct packed {
    logic       haltreq;
    logic       resumereq;
    logic       hartreset;
    logic       ackhavereset;
    logic       zero1;
    logic       hasel;
    logic [9:0] hartsello;
    logic [9:0] hartselhi;
    logic [1:0] zero0;
    logic       setresethaltreq;
    logic       clrresethaltreq;
    logic       ndmreset;
    logic       dmactive;
  } dmcontrol_t;

  // status of the hart picked by hartsel
  typedef struct packed {
    logic halted;
    logic running;
    logic unavailable;
    logic resumeack;
    logic havereset;
    logic nonexistent;
  } hart_status_t;

  localparam dm_addr_t AddrData0      = 7'h04;
  localparam dm_addr_t AddrDmControl  = 7'h10;
  localparam dm_addr_t AddrDmStatus   = 7'h11;
  localparam dm_addr_t AddrAbstractCs = 7'h16;
  localparam dm_addr_t AddrCommand    = 7'h17;

  // debug spec 0.13
  localparam logic [3:0] DbgVersion = 4'd2;

endpackage

`default_nettype wire

/* source/dm_resp_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module dm_resp_fifo (
  input  logic             clk_i,
  input  logic             rst_ni,
  input  logic             push_i,
  input  dm_pkg::dm_word_t data_i,
  input  logic             pop_i,
  output logic             full_o,
  output logic             empty_o,
  output dm_pkg::dm_word_t data_o
);
  import dm_pkg::*;

  dm_word_t   mem_q [2];
  logic       wr_ptr_q;
  logic       rd_ptr_q;
  logic [1:0] count_q;

  assign full_o  = (count_q == 2'd2);
  assign empty_o = (count_q == 2'd0);
  assign data_o  = mem_q[rd_ptr_q];

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // pointers and fill level
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop_i) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      case ({push_i, pop_i})
        2'b10:   count_q <= count_q + 2'd1;
        2'b01:   count_q <= count_q - 2'd1;
        default: ;
      endcase
    end
  end

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop_i |-> !empty_o);

endmodule

`default_nettype wire

/* source/dm_hart_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module dm_hart_ctrl #(
  parameter int unsigned NrHarts = 4
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  dm_pkg::dmcontrol_t   dmcontrol_i,
  input  logic                 ack_havereset_i,
  input  logic [NrHarts-1:0]   halted_i,
  input  logic [NrHarts-1:0]   unavailable_i,
  input  logic [NrHarts-1:0]   resumeack_i,
  output logic [NrHarts-1:0]   haltreq_o,
  output logic [NrHarts-1:0]   resumereq_o,
  output dm_pkg::hart_status_t hart_status_o
);
  import dm_pkg::*;

  localparam int unsigned SelW = (NrHarts > 1) ? $clog2(NrHarts) : 1;

  hartsel_t           hartsel;
  logic [SelW-1:0]    sel;
  logic               hart_exists;
  logic [NrHarts-1:0] havereset_d, havereset_q;

  assign hartsel     = {dmcontrol_i.hartselhi, dmcontrol_i.hartsello};
  assign hart_exists = (hartsel < NrHarts);
  assign sel         = hartsel[SelW-1:0];

  // request fan-out and status of the selected hart
  always_comb begin
    haltreq_o                 = '0;
    resumereq_o               = '0;
    hart_status_o             = '0;
    hart_status_o.nonexistent = ~hart_exists;
    if (hart_exists) begin
      haltreq_o[sel]            = dmcontrol_i.haltreq;
      resumereq_o[sel]          = dmcontrol_i.resumereq;
      // unavailable masks both halted and running
      hart_status_o.halted      = halted_i[sel] & ~unavailable_i[sel];
      hart_status_o.running    = ~halted_i[sel] & ~unavailable_i[sel];
      hart_status_o.unavailable = unavailable_i[sel];
      hart_status_o.resumeack   = resumeack_i[sel];
      hart_status_o.havereset   = havereset_q[sel];
    end
  end

  // --------------------
  // havereset flags
  // --------------------
  always_comb begin
    havereset_d = havereset_q;
    if (ack_havereset_i && hart_exists) begin
      havereset_d[sel] = 1'b0;
    end
    // ndmreset resets every hart
    if (dmcontrol_i.ndmreset) begin
      havereset_d = '1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      havereset_q <= '1;
    end else begin
      havereset_q <= havereset_d;
    end
  end

  a_haltreq_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(haltreq_o));

endmodule

`default_nettype wire

/* source/dm_csr_file.sv */
`timescale 1ns/1ps
`default_nettype none

module dm_csr_file #(
  parameter int unsigned NrHarts   = 4,
  parameter int unsigned DataCount = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             dmi_req_valid_i,
  output logic                             dmi_req_ready_o,
  input  dm_pkg::dmi_req_t                 dmi_req_i,
  output logic                             resp_push_o,
  output dm_pkg::dm_word_t                 resp_data_o,
  input  logic                             resp_full_i,
  output dm_pkg::dmcontrol_t               dmcontrol_o,
  output logic                             ack_havereset_o,
  input  dm_pkg::hart_status_t             hart_status_i,
  output logic                             clear_resumeack_o,
  output logic                             cmd_valid_o,
  output dm_pkg::dm_word_t                 cmd_o,
  input  logic                             cmdbusy_i,
  input  logic                             cmderror_valid_i,
  input  dm_pkg::cmderr_e                  cmderror_i,
  input  logic                             data_valid_i,
  input  dm_pkg::dm_word_t [DataCount-1:0] data_i,
  output dm_pkg::dm_word_t [DataCount-1:0] data_o,
  output logic                             ndmreset_o,
  output logic                             dmactive_o
);
  import dm_pkg::*;

  localparam int unsigned DataIdxW = (DataCount > 1) ? $clog2(DataCount) : 1;

  dmcontrol_t               dmcontrol_d, dmcontrol_q;
  dmcontrol_t               dmcontrol_wr;
  cmderr_e                  cmderr_d, cmderr_q;
  dm_word_t                 command_d, command_q;
  dm_word_t [DataCount-1:0] data_d, data_q;
  logic                     cmd_valid_d, cmd_valid_q;

  logic                req_accept;
  logic                req_read;
  logic                req_write;
  logic                data_hit;
  dm_addr_t            data_off;
  logic [DataIdxW-1:0] data_idx;
  logic                busy;
  dm_word_t            dmstatus;
  dm_word_t            abstractcs;

  // --------------------
  // request decode
  // --------------------
  assign dmi_req_ready_o = ~resp_full_i;
  assign req_accept      = dmi_req_valid_i & dmi_req_ready_o;
  assign req_read        = req_accept & (dmi_req_i.op == DtmRead);
  assign req_write       = req_accept & (dmi_req_i.op == DtmWrite);
  // every accepted request gets a response word, writes and nops too
  assign resp_push_o     = req_accept;

  assign dmcontrol_wr = dmcontrol_t'(dmi_req_i.data);
  assign data_off     = dmi_req_i.addr - AddrData0;
  assign data_hit     = (dmi_req_i.addr >= AddrData0) && (data_off < DataCount);
  assign data_idx     = data_off[DataIdxW-1:0];

  // a command issued last cycle counts as busy until the hart raises cmdbusy
  assign busy = cmdbusy_i | cmd_valid_q;

  // --------------------
  // read-only views
  // --------------------
  always_comb begin
    dmstatus        = '0;
    dmstatus[3:0]   = DbgVersion;
    // no authentication
    dmstatus[7]     = 1'b1;
    dmstatus[9:8]   = {2{hart_status_i.halted}};
    dmstatus[11:10] = {2{hart_status_i.running}};
    dmstatus[13:12] = {2{hart_status_i.unavailable}};
    dmstatus[15:14] = {2{hart_status_i.nonexistent}};
    dmstatus[17:16] = {2{hart_status_i.resumeack}};
    dmstatus[19:18] = {2{hart_status_i.havereset}};

    abstractcs       = '0;
    abstractcs[3:0]  = 4'(DataCount);
    abstractcs[10:8] = cmderr_q;
    abstractcs[12]   = busy;
  end

  // --------------------
  // read and write logic
  // --------------------
  always_comb begin
    dmcontrol_d       = dmcontrol_q;
    cmderr_d          = cmderr_q;
    command_d         = command_q;
    data_d            = data_q;
    cmd_valid_d       = 1'b0;
    resp_data_o       = '0;
    ack_havereset_o   = 1'b0;
    clear_resumeack_o = 1'b0;

    // command reads as zero through the default branch
    if (req_read) begin
      case (dmi_req_i.addr)
        AddrDmControl:  resp_data_o = dmcontrol_q;
        AddrDmStatus:   resp_data_o = dmstatus;
        AddrAbstractCs: resp_data_o = abstractcs;
        default:        resp_data_o = data_hit ? data_q[data_idx] : '0;
      endcase
    end

    // data access starts the last command again unless busy
    if (req_accept && data_hit && (dmi_req_i.op != DtmNop)) begin
      if (!busy) begin
        cmd_valid_d = 1'b1;
        if (req_write) begin
          data_d[data_idx] = dmi_req_i.data;
        end
      end else if (cmderr_q == CmdErrNone) begin
        cmderr_d = CmdErrBusy;
      end
    end

    if (req_write) begin
      case (dmi_req_i.addr)
        AddrDmControl: begin
          dmcontrol_d       = dmcontrol_wr;
          ack_havereset_o   = dmcontrol_wr.ackhavereset;
          clear_resumeack_o = dmcontrol_q.dmactive & ~dmcontrol_q.resumereq &
                              dmcontrol_wr.resumereq;
        end
        AddrAbstractCs: begin
          // cmderr is W1C
          if (!busy) begin
            cmderr_d = cmderr_e'(cmderr_q & ~dmi_req_i.data[10:8]);
          end else if (cmderr_q == CmdErrNone) begin
            cmderr_d = CmdErrBusy;
          end
        end
        AddrCommand: begin
          if (!busy) begin
            cmd_valid_d = 1'b1;
            command_d   = dmi_req_i.data;
          end else if (cmderr_q == CmdErrNone) begin
            cmderr_d = CmdErrBusy;
          end
        end
        default: ;
      endcase
    end

    // hart side wins over the debugger
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (data_valid_i) begin
      data_d = data_i;
    end

    // unsupported dmcontrol fields stay zero
    dmcontrol_d.hartreset       = 1'b0;
    dmcontrol_d.ackhavereset    = 1'b0;
    dmcontrol_d.zero1           = 1'b0;
    dmcontrol_d.hasel           = 1'b0;
    dmcontrol_d.zero0           = '0;
    dmcontrol_d.setresethaltreq = 1'b0;
    dmcontrol_d.clrresethaltreq = 1'b0;

    if (dmcontrol_q.resumereq && hart_status_i.resumeack) begin
      dmcontrol_d.resumereq = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
      cmderr_q    <= CmdErrNone;
      command_q   <= '0;
      data_q      <= '0;
      cmd_valid_q <= 1'b0;
    end else if (!dmcontrol_q.dmactive) begin
      // inactive DM, only dmactive itself can be written
      dmcontrol_q          <= '0;
      dmcontrol_q.dmactive <= dmcontrol_d.dmactive;
      cmderr_q             <= CmdErrNone;
      command_q            <= '0;
      data_q               <= '0;
      cmd_valid_q          <= 1'b0;
    end else begin
      dmcontrol_q <= dmcontrol_d;
      cmderr_q    <= cmderr_d;
      command_q   <= command_d;
      data_q      <= data_d;
      cmd_valid_q <= cmd_valid_d;
    end
  end

  assign dmcontrol_o = dmcontrol_q;
  assign cmd_o       = command_q;
  assign cmd_valid_o = cmd_valid_q;
  assign data_o      = data_q;
  assign ndmreset_o  = dmcontrol_q.ndmreset;
  assign dmactive_o  = dmcontrol_q.dmactive;

  // --------------------
  // assertions
  // --------------------
  a_push_not_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    resp_push_o |-> !resp_full_i);

  a_cmd_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_o |=> !cmd_valid_o);

endmodule

`default_nettype wire

/* source/dm_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dm_top #(
  parameter int unsigned NrHarts   = 4,
  parameter int unsigned DataCount = 2
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  // DMI
  input  logic                             dmi_req_valid_i,
  output logic                             dmi_req_ready_o,
  input  dm_pkg::dmi_req_t                 dmi_req_i,
  output logic                             dmi_resp_valid_o,
  input  logic                             dmi_resp_ready_i,
  output dm_pkg::dmi_resp_t                dmi_resp_o,
  // global control
  output logic                             ndmreset_o,
  output logic                             dmactive_o,
  // hart side
  input  logic [NrHarts-1:0]               halted_i,
  input  logic [NrHarts-1:0]               unavailable_i,
  input  logic [NrHarts-1:0]               resumeack_i,
  output logic [NrHarts-1:0]               haltreq_o,
  output logic [NrHarts-1:0]               resumereq_o,
  output logic                             clear_resumeack_o,
  // abstract commands
  output logic                             cmd_valid_o,
  output dm_pkg::dm_word_t                 cmd_o,
  input  logic                             cmdbusy_i,
  input  logic                             cmderror_valid_i,
  input  dm_pkg::cmderr_e                  cmderror_i,
  input  logic                             data_valid_i,
  input  dm_pkg::dm_word_t [DataCount-1:0] data_i,
  output dm_pkg::dm_word_t [DataCount-1:0] data_o
);
  import dm_pkg::*;

  logic         resp_push;
  logic         resp_pop;
  logic         resp_full;
  logic         resp_empty;
  dm_word_t     resp_data;
  dm_word_t     resp_word;
  dmcontrol_t   dmcontrol;
  logic         ack_havereset;
  hart_status_t hart_status;

  assign dmi_resp_valid_o = ~resp_empty;
  assign resp_pop         = dmi_resp_ready_i & ~resp_empty;
  // every response reports success
  assign dmi_resp_o       = '{data: resp_word, resp: DtmSuccess};

  dm_csr_file #(
    .NrHarts   (NrHarts),
    .DataCount (DataCount)
  ) u_csr_file (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .dmi_req_valid_i   (dmi_req_valid_i),
    .dmi_req_ready_o   (dmi_req_ready_o),
    .dmi_req_i         (dmi_req_i),
    .resp_push_o       (resp_push),
    .resp_data_o       (resp_data),
    .resp_full_i       (resp_full),
    .dmcontrol_o       (dmcontrol),
    .ack_havereset_o   (ack_havereset),
    .hart_status_i     (hart_status),
    .clear_resumeack_o (clear_resumeack_o),
    .cmd_valid_o       (cmd_valid_o),
    .cmd_o             (cmd_o),
    .cmdbusy_i         (cmdbusy_i),
    .cmderror_valid_i  (cmderror_valid_i),
    .cmderror_i        (cmderror_i),
    .data_valid_i      (data_valid_i),
    .data_i            (data_i),
    .data_o            (data_o),
    .ndmreset_o        (ndmreset_o),
    .dmactive_o        (dmactive_o)
  );

  dm_hart_ctrl #(
    .NrHarts (NrHarts)
  ) u_hart_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .dmcontrol_i     (dmcontrol),
    .ack_havereset_i (ack_havereset),
    .halted_i        (halted_i),
    .unavailable_i   (unavailable_i),
    .resumeack_i     (resumeack_i),
    .haltreq_o       (haltreq_o),
    .resumereq_o     (resumereq_o),
    .hart_status_o   (hart_status)
  );

  dm_resp_fifo u_resp_fifo (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .push_i  (resp_push),
    .data_i  (resp_data),
    .pop_i   (resp_pop),
    .full_o  (resp_full),
    .empty_o (resp_empty),
    .data_o  (resp_word)
  );

endmodule

`default_nettype wire

/* dv/tb_dm_top.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_dm_top;
  import dm_pkg::*;

  localparam int unsigned NrHarts   = 4;
  localparam int unsigned DataCount = 2;
  localparam int          ClkPeriod = 8;
  localparam int unsigned Seed      = 95532;

  localparam dm_word_t StrobeData0 = 32'h5A00_11C3;
  localparam dm_word_t StrobeData1 = 32'h3C00_22E1;

  // hart-side stimulus of one table row
  typedef struct packed {
    logic [NrHarts-1:0] halted;
    logic [NrHarts-1:0] unavail;
    logic [NrHarts-1:0] resumeack;
    logic               cmdbusy;
    logic               dvalid;
  } hart_in_t;

  typedef struct packed {
    dtm_op_e            op;
    dm_addr_t           addr;
    dm_word_t           wdata;
    hart_in_t           hin;
    dm_word_t           exp_rdata;
    logic [NrHarts-1:0] exp_haltreq;
    logic [NrHarts-1:0] exp_resumereq;
    logic               exp_cmd_valid;
    logic               exp_clr_ack;
    dm_word_t           exp_cmd;
  } row_t;

  logic                       clk_i;
  logic                       rst_ni;
  logic                       dmi_req_valid_i;
  logic                       dmi_req_ready_o;
  dmi_req_t                   dmi_req_i;
  logic                       dmi_resp_valid_o;
  logic                       dmi_resp_ready_i;
  dmi_resp_t                  dmi_resp_o;
  logic                       ndmreset_o;
  logic                       dmactive_o;
  logic [NrHarts-1:0]         halted_i;
  logic [NrHarts-1:0]         unavailable_i;
  logic [NrHarts-1:0]         resumeack_i;
  logic [NrHarts-1:0]         haltreq_o;
  logic [NrHarts-1:0]         resumereq_o;
  logic                       clear_resumeack_o;
  logic                       cmd_valid_o;
  dm_word_t                   cmd_o;
  logic                       cmdbusy_i;
  logic                       cmderror_valid_i;
  cmderr_e                    cmderror_i;
  logic                       data_valid_i;
  dm_word_t [DataCount-1:0]   data_i;
  dm_word_t [DataCount-1:0]   data_o;

  row_t rows[$];
  int   err_count     = 0;
  int   check_count   = 0;
  int   test_count    = 0;
  int   cycle_count   = 0;
  int   timeout_limit = 1000;

  dm_top #(
    .NrHarts   (NrHarts),
    .DataCount (DataCount)
  ) UUT (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .dmi_req_valid_i   (dmi_req_valid_i),
    .dmi_req_ready_o   (dmi_req_ready_o),
    .dmi_req_i         (dmi_req_i),
    .dmi_resp_valid_o  (dmi_resp_valid_o),
    .dmi_resp_ready_i  (dmi_resp_ready_i),
    .dmi_resp_o        (dmi_resp_o),
    .ndmreset_o        (ndmreset_o),
    .dmactive_o        (dmactive_o),
    .halted_i          (halted_i),
    .unavailable_i     (unavailable_i),
    .resumeack_i       (resumeack_i),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o),
    .cmd_valid_o       (cmd_valid_o),
    .cmd_o             (cmd_o),
    .cmdbusy_i         (cmdbusy_i),
    .cmderror_valid_i  (cmderror_valid_i),
    .cmderror_i        (cmderror_i),
    .data_valid_i      (data_valid_i),
    .data_i            (data_i),
    .data_o            (data_o)
  );

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= timeout_limit) begin
      $display("timeout: run did not finish within %0d cycles", timeout_limit);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // --------------------
  // expected register words
  // --------------------
  // dmstatus: version 2 and authenticated in the low byte, any/all pairs above
  function automatic dm_word_t status_word(input logic halted, input logic running,
                                           input logic unavail, input logic nonexist,
                                           input logic resumeack, input logic havereset);
    status_word = {12'h000, {2{havereset}}, {2{resumeack}}, {2{nonexist}},
                   {2{unavail}}, {2{running}}, {2{halted}}, 8'h82};
  endfunction

  function automatic dm_word_t ctrl_word(input logic haltreq, input logic resumereq,
                                         input logic ackhavereset, input logic [9:0] hartsel,
                                         input logic ndmreset, input logic dmactive);
    ctrl_word = {haltreq, resumereq, 1'b0, ackhavereset, 2'b00, hartsel, 10'h000,
                 4'h0, ndmreset, dmactive};
  endfunction

  function automatic dm_word_t acs_word(input logic [2:0] cmderr, input logic busy);
    acs_word = {19'h0, busy, 1'b0, cmderr, 4'h0, 4'(DataCount)};
  endfunction

  function automatic hart_in_t hart_in(input logic [NrHarts-1:0] halted,
                                       input logic [NrHarts-1:0] unavail,
                                       input logic [NrHarts-1:0] resumeack,
                                       input logic cmdbusy, input logic dvalid);
    hart_in = '{halted: halted, unavail: unavail, resumeack: resumeack,
                cmdbusy: cmdbusy, dvalid: dvalid};
  endfunction

  function automatic void add_row(input dtm_op_e op, input dm_addr_t addr,
                                  input dm_word_t wdata, input hart_in_t hin,
                                  input dm_word_t exp_rdata,
                                  input logic [NrHarts-1:0] exp_halt,
                                  input logic [NrHarts-1:0] exp_resume,
                                  input logic exp_cmd_valid, input logic exp_clr,
                                  input dm_word_t exp_cmd);
    row_t r;
    r.op            = op;
    r.addr          = addr;
    r.wdata         = wdata;
    r.hin           = hin;
    r.exp_rdata     = exp_rdata;
    r.exp_haltreq   = exp_halt;
    r.exp_resumereq = exp_resume;
    r.exp_cmd_valid = exp_cmd_valid;
    r.exp_clr_ack   = exp_clr;
    r.exp_cmd       = exp_cmd;
    rows.push_back(r);
  endfunction

  // --------------------
  // stimulus table
  // --------------------
  function automatic void load_table();
    hart_in_t idle;
    hart_in_t busy;
    hart_in_t halt2;
    hart_in_t halt1;
    hart_in_t ack1_halted;
    hart_in_t ack1;
    hart_in_t strobe;
    dm_word_t d0;
    dm_word_t d1;
    dm_word_t d2;
    dm_word_t cmd;
    idle        = hart_in(4'h0, 4'h0, 4'h0, 1'b0, 1'b0);
    busy        = hart_in(4'h0, 4'h0, 4'h0, 1'b1, 1'b0);
    halt2       = hart_in(4'h4, 4'h0, 4'h0, 1'b0, 1'b0);
    halt1       = hart_in(4'h2, 4'h0, 4'h0, 1'b0, 1'b0);
    ack1_halted = hart_in(4'h2, 4'h0, 4'h2, 1'b0, 1'b0);
    ack1        = hart_in(4'h0, 4'h0, 4'h2, 1'b0, 1'b0);
    strobe      = hart_in(4'h0, 4'h0, 4'h0, 1'b0, 1'b1);
    d0          = $urandom();
    d1          = $urandom();
    d2          = $urandom();
    cmd         = 32'h0022_1002;

    // after reset, ackhavereset, ndmreset
    add_row(DtmRead, AddrDmControl, '0, idle, '0, 4'h0, 4'h0, 1'b0, 1'b0, '0);
    add_row(DtmRead, AddrDmStatus, '0, idle, status_word(0, 1, 0, 0, 0, 1),
            4'h0, 4'h0, 1'b0, 1'b0, '0);
    add_row(DtmWrite, AddrDmControl, ctrl_word(0, 0, 1, 10'd0, 0, 1), idle, '0,
            4'h0, 4'h0, 1'b0, 1'b0, '0);
    add_row(DtmRead, AddrDmStatus, '0, idle, status_word(0, 1, 0, 0, 0, 0),
            4'h0, 4'h0, 1'b0, 1'b0, '0);
    add_row(DtmWrite, AddrDmControl, ctrl_word(0, 0, 0, 10'd0, 1, 1), idle, '0,
            4'h0, 4'h0, 1'b0, 1'b0, '0);
    add_row(DtmRead, AddrDmStatus, '0, idle, status_word(0, 1, 0, 0, 0, 1),
            4'h0, 4'h0, 1'b0, 1'b0, '0);
    // halt requests
    add_row(DtmWrite, AddrDmControl, ctrl_word(1, 0, 0, 10'd2, 0, 1), idle, '0,
            4'h4, 4'h0, 1'b0, 1'b0, '0);
    add_row(DtmRead, AddrDmStatus, '0, halt2, status_word(1, 0, 0, 0, 0, 1),
            4'h4, 4'h0, 1'b0, 1'b0, '0);
    add_row(DtmWrite, AddrDmControl, ctrl_word(1, 0, 0, 10'd5, 0, 1), halt2, '0,
            4'h0, 4'h0, 1'b0, 1'b0, '0);
    add_row(DtmRead, AddrDmStatus, '0, idle, status_word(0, 0, 0, 1, 0, 0),
            4'h0, 4'h0, 1'b0, 1'b0, '0);
    add_row(DtmWrite, AddrDmControl, '0, idle, '0, 4'h0, 4'h0, 1'b0, 1'b0, '0);
    add_row(DtmRead, AddrDmControl, '0, idle, '0, 4'h0, 4'h0, 1'b0, 1'b0, '0);
    // resume handshake on hart 1
    add_row(DtmWrite, AddrDmControl, ctrl_word(0, 0, 0, 10'd0, 0, 1), idle, '0,
            4'h0, 4'h0, 1'b0, 1'b0, '0);
    add_row(DtmWrite, AddrDmControl, ctrl_word(0, 1, 0, 10'd1, 0, 1), halt1, '0,
            4'h0, 4'h2, 1'b0, 1'b1, '0);
    add_row(DtmRead, AddrDmControl, '0, ack1_halted, ctrl_word(0, 1, 0, 10'd1, 0, 1),
            4'h0, 4'h0, 1'b0, 1'b0, '0);
    add_row(DtmRead, AddrDmControl, '0, ack1, ctrl_word(0, 0, 0, 10'd1, 0, 1),
            4'h0, 4'h0, 1'b0, 1'b0, '0);
    add_row(DtmRead, AddrDmStatus, '0, ack1, status_word(0, 1, 0, 0, 1, 1),
            4'h0, 4'h0, 1'b0, 1'b0, '0);
    // abstract command and cmderr
    add_row(DtmWrite, AddrCommand, cmd, idle, '0, 4'h0, 4'h0, 1'b1, 1'b0, cmd);
    add_row(DtmWrite, AddrCommand, 32'h0033_2003, busy, '0, 4'h0, 4'h0, 1'b0, 1'b0, cmd);
    add_row(DtmRead, AddrAbstractCs, '0, busy, acs_word(3'd1, 1'b1),
            4'h0, 4'h0, 1'b0, 1'b0, cmd);
    add_row(DtmWrite, AddrAbstractCs, 32'h0000_0700, idle, '0,
            4'h0, 4'h0, 1'b0, 1'b0, cmd);
    add_row(DtmRead, AddrAbstractCs, '0, idle, acs_word(3'd0, 1'b0),
            4'h0, 4'h0, 1'b0, 1'b0, cmd);
    // data registers, every access restarts the command when idle
    add_row(DtmWrite, AddrData0, d0, idle, '0, 4'h0, 4'h0, 1'b1, 1'b0, cmd);
    add_row(DtmWrite, AddrData0 + 7'd1, d1, idle, '0, 4'h0, 4'h0, 1'b1, 1'b0, cmd);
    add_row(DtmRead, AddrData0, '0, idle, d0, 4'h0, 4'h0, 1'b1, 1'b0, cmd);
    add_row(DtmRead, AddrData0 + 7'd1, '0, idle, d1, 4'h0, 4'h0, 1'b1, 1'b0, cmd);
    add_row(DtmWrite, AddrData0, d2, busy, '0, 4'h0, 4'h0, 1'b0, 1'b0, cmd);
    add_row(DtmRead, AddrAbstractCs, '0, busy, acs_word(3'd1, 1'b1),
            4'h0, 4'h0, 1'b0, 1'b0, cmd);
    add_row(DtmRead, AddrData0, '0, idle, d0, 4'h0, 4'h0, 1'b1, 1'b0, cmd);
    add_row(DtmWrite, AddrAbstractCs, 32'h0000_0700, idle, '0,
            4'h0, 4'h0, 1'b0, 1'b0, cmd);
    add_row(DtmNop, '0, '0, strobe, '0, 4'h0, 4'h0, 1'b0, 1'b0, cmd);
    add_row(DtmRead, AddrData0, '0, idle, StrobeData0, 4'h0, 4'h0, 1'b1, 1'b0, cmd);
    add_row(DtmRead, AddrData0 + 7'd1, '0, idle, StrobeData1,
            4'h0, 4'h0, 1'b1, 1'b0, cmd);
    add_row(DtmRead, AddrAbstractCs, '0, idle, acs_word(3'd0, 1'b0),
            4'h0, 4'h0, 1'b0, 1'b0, cmd);
  endfunction

  // --------------------
  // checks and sequences
  // --------------------
  task automatic check_value(input string name, input dm_word_t got, input dm_word_t exp);
    check_count++;
    if (got !== exp) begin
      err_count++;
      $display("ERR %s: got 0x%08h, expected 0x%08h", name, got, exp);
    end
  endtask

  task automatic report_test(input string label, input int errs_before);
    test_count++;
    if (err_count == errs_before) begin
      $display("test %0d %s: passed", test_count, label);
    end else begin
      $display("test %0d %s: failed", test_count, label);
    end
  endtask

  task automatic check_reset_state();
    int errs_before;
    errs_before = err_count;
    check_value("cmd_valid_o", cmd_valid_o, '0);
    check_value("clear_resumeack_o", clear_resumeack_o, '0);
    check_value("haltreq_o", haltreq_o, '0);
    check_value("resumereq_o", resumereq_o, '0);
    check_value("ndmreset_o", ndmreset_o, '0);
    check_value("dmactive_o", dmactive_o, '0);
    check_value("dmi_resp_valid_o", dmi_resp_valid_o, '0);
    check_value("dmi_req_ready_o", dmi_req_ready_o, 32'd1);
    report_test("reset state", errs_before);
  endtask

  task automatic apply_row(input int idx, input row_t r);
    int errs_before;
    errs_before = err_count;
    @(negedge clk_i);
    halted_i           = r.hin.halted;
    unavailable_i      = r.hin.unavail;
    resumeack_i        = r.hin.resumeack;
    cmdbusy_i          = r.hin.cmdbusy;
    data_valid_i       = r.hin.dvalid;
    dmi_req_i.addr     = r.addr;
    dmi_req_i.op       = r.op;
    dmi_req_i.data     = r.wdata;
    dmi_req_valid_i    = 1'b1;
    #(ClkPeriod / 4);
    while (!dmi_req_ready_o) begin
      @(negedge clk_i);
      #(ClkPeriod / 4);
    end
    // combinational pulse, seen in the acceptance cycle
    check_value("clear_resumeack_o", clear_resumeack_o, r.exp_clr_ack);
    @(posedge clk_i);
    @(negedge clk_i);
    check_value("haltreq_o", haltreq_o, r.exp_haltreq);
    check_value("resumereq_o", resumereq_o, r.exp_resumereq);
    check_value("cmd_valid_o", cmd_valid_o, r.exp_cmd_valid);
    check_value("cmd_o", cmd_o, r.exp_cmd);
    // dmactive and ndmreset follow the written dmcontrol word
    if (r.op == DtmWrite && r.addr == AddrDmControl) begin
      check_value("dmactive_o", dmactive_o, r.wdata[0]);
      check_value("ndmreset_o", ndmreset_o, r.wdata[1] & r.wdata[0]);
    end
    // hart-side view of the data registers
    if (r.op == DtmRead && r.addr >= AddrData0 && r.addr < AddrData0 + DataCount) begin
      check_value("data_o", data_o[r.addr - AddrData0], r.exp_rdata);
    end
    dmi_req_valid_i = 1'b0;
    dmi_req_i       = '0;
    data_valid_i    = 1'b0;
    while (!dmi_resp_valid_o) begin
      @(negedge clk_i);
    end
    check_value("dmi_resp_o.data", dmi_resp_o.data, r.exp_rdata);
    check_value("dmi_resp_o.resp", dmi_resp_o.resp, DtmSuccess);
    report_test($sformatf("row %0d %s addr 0x%02h", idx, r.op.name(), r.addr), errs_before);
  endtask

  task automatic check_backpressure();
    int errs_before;
    errs_before = err_count;
    @(negedge clk_i);
    dmi_resp_ready_i = 1'b0;
    dmi_req_i        = '{addr: AddrDmControl, op: DtmRead, data: '0};
    dmi_req_valid_i  = 1'b1;
    #(ClkPeriod / 4);
    check_value("dmi_req_ready_o", dmi_req_ready_o, 32'd1);
    @(negedge clk_i);
    dmi_req_i.addr = AddrAbstractCs;
    #(ClkPeriod / 4);
    check_value("dmi_req_ready_o", dmi_req_ready_o, 32'd1);
    // queue is full now, a third request has to wait
    @(negedge clk_i);
    dmi_req_i.addr = AddrDmStatus;
    #(ClkPeriod / 4);
    check_value("dmi_req_ready_o", dmi_req_ready_o, '0);
    @(negedge clk_i);
    check_value("dmi_req_ready_o", dmi_req_ready_o, '0);
    dmi_req_valid_i  = 1'b0;
    dmi_req_i        = '0;
    dmi_resp_ready_i = 1'b1;
    check_value("dmi_resp_valid_o", dmi_resp_valid_o, 32'd1);
    check_value("dmi_resp_o.data", dmi_resp_o.data, ctrl_word(0, 0, 0, 10'd1, 0, 1));
    @(negedge clk_i);
    check_value("dmi_resp_valid_o", dmi_resp_valid_o, 32'd1);
    check_value("dmi_resp_o.data", dmi_resp_o.data, acs_word(3'd0, 1'b0));
    @(negedge clk_i);
    check_value("dmi_resp_valid_o", dmi_resp_valid_o, '0);
    check_value("dmi_req_ready_o", dmi_req_ready_o, 32'd1);
    report_test("back-pressure", errs_before);
  endtask

  initial begin
    void'($urandom(Seed));
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    dmi_req_valid_i  = 1'b0;
    dmi_req_i        = '0;
    dmi_resp_ready_i = 1'b1;
    halted_i         = '0;
    unavailable_i    = '0;
    resumeack_i      = '0;
    cmdbusy_i        = 1'b0;
    cmderror_valid_i = 1'b0;
    cmderror_i       = CmdErrNone;
    data_valid_i     = 1'b0;
    data_i[0]        = StrobeData0;
    data_i[1]        = StrobeData1;

    load_table();
    timeout_limit = rows.size() * 8 + 200;

    repeat (4) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;

    check_reset_state();
    foreach (rows[i]) begin
      apply_row(i, rows[i]);
    end
    check_backpressure();

    $display("summary: %0d tests, %0d checks, %0d mismatches", test_count, check_count,
             err_count);
    if (err_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb.f */
source/dm_pkg.sv
source/dm_resp_fifo.sv
source/dm_hart_ctrl.sv
source/dm_csr_file.sv
source/dm_top.sv
dv/tb_dm_top.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the DM register block testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dm_top \
  -f tb.f -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "run_sim: compile step failed"
  exit 1
fi

sim_out=$(./obj_dir/Vtb_dm_top)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "run_sim: simulator exited with status $sim_status"
  exit 1
fi

if echo "$sim_out" | grep -q "^NO ERRORS$"; then
  exit 0
fi
exit 1
